//--- Makefile
# Verilator simulation of the triple-redundant 2R1W register file
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_voting_sram
LOG       ?= sim.log
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q 'All tests passed!' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- list.f
tmr_pkg.sv
tmr_bank.sv
tmr_voter.sv
tmr_scrubber.sv
voting_sram_2r1w.sv
tb_voting_sram.sv

//--- tb_voting_sram.sv
/*
 * Directed testbench for the triple-redundant 2R1W register file
 * Shadow memory with expected scrub count, value check task, and tests
 * for reset values, clean reads, scrubbing, port priority, store bypass
 * and failed votes
 */
module tb_voting_sram;

    import tmr_pkg::*;

    // Watchdog limit for the whole run and limit for the pulse wait
    localparam int MAX_CYCLES  = 5000;
    localparam int PULSE_LIMIT = 8;

    logic                   clk = 1'b0;
    logic                   arst_n;
    rd_req_t                rd1;
    rd_req_t                rd2;
    wr_req_t                wr;
    inject_t                inject;
    logic [DATA_WIDTH-1:0]  read1_data;
    logic [DATA_WIDTH-1:0]  read2_data;
    vote_status_e           read1_status;
    vote_status_e           read2_status;
    logic [COUNT_WIDTH-1:0] scrub_count;
    logic                   uncorrectable;

    // True memory contents as seen through a correct vote
    logic [DATA_WIDTH-1:0] shadow [DEPTH];

    // Predicted scrub count and run statistics
    int     exp_scrub;
    int     n_checks;
    int     n_errors;
    integer seed;

    voting_sram_2r1w i_voting_sram_2r1w (
        .clk           (clk),
        .arst_n        (arst_n),
        .rd1           (rd1),
        .rd2           (rd2),
        .wr            (wr),
        .inject        (inject),
        .read1_data    (read1_data),
        .read2_data    (read2_data),
        .read1_status  (read1_status),
        .read2_status  (read2_status),
        .scrub_count   (scrub_count),
        .uncorrectable (uncorrectable)
    );

    always #10 clk = ~clk;

    // Compares one value and reports a mismatch with time and both values
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Failures that are not a wrong value
    task automatic report_error(input string msg);
        n_errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    function automatic logic [DATA_WIDTH-1:0] shadow_at(input int addr);
        return shadow[ADDR_WIDTH'(addr)];
    endfunction

    function automatic rd_req_t rd_at(input int addr);
        rd_req_t r;
        r.en   = 1'b1;
        r.addr = ADDR_WIDTH'(addr);
        return r;
    endfunction

    function automatic wr_req_t wr_at(input int addr, input logic [DATA_WIDTH-1:0] data);
        wr_req_t w;
        w.en   = 1'b1;
        w.addr = ADDR_WIDTH'(addr);
        w.data = data;
        return w;
    endfunction

    // Drives one cycle of requests, then waits until the registered
    // results of that cycle are stable
    task automatic run_cycle(input rd_req_t r1, input rd_req_t r2, input wr_req_t w);
        @(posedge clk);
        rd1 <= r1;
        rd2 <= r2;
        wr  <= w;
        @(posedge clk);
        rd1 <= '0;
        rd2 <= '0;
        wr  <= '0;
        @(negedge clk);
        // A store reaches all three copies
        if (w.en) begin
            shadow[w.addr] = w.data;
        end
    endtask

    task automatic store_word(input int addr, input logic [DATA_WIDTH-1:0] data);
        run_cycle('0, '0, wr_at(addr, data));
    endtask

    task automatic read_one(input int port, input int addr);
        if (port == 1) begin
            run_cycle(rd_at(addr), '0, '0);
        end else begin
            run_cycle('0, rd_at(addr), '0);
        end
    endtask

    // Corrupts one copy only, the shadow keeps the true word
    task automatic inject_fault(input bank_id_e bank, input int addr,
                                input logic [DATA_WIDTH-1:0] mask);
        inject_t f;
        f.en   = 1'b1;
        f.bank = bank;
        f.addr = ADDR_WIDTH'(addr);
        f.data = shadow_at(addr) ^ mask;
        @(posedge clk);
        inject <= f;
        @(posedge clk);
        inject <= '0;
        @(negedge clk);
    endtask

    task automatic check_port(input int port, input int addr, input vote_status_e st);
        if (port == 1) begin
            check_value("read1_data", read1_data, shadow_at(addr));
            check_value("read1_status", 32'(read1_status), 32'(st));
        end else begin
            check_value("read2_data", read2_data, shadow_at(addr));
            check_value("read2_status", 32'(read2_status), 32'(st));
        end
    endtask

    task automatic check_count();
        check_value("scrub_count", 32'(scrub_count), 32'(exp_scrub));
    endtask

    // Measures how many cycles uncorrectable stays high
    task automatic wait_pulse_end(output int width);
        width = 0;
        for (int i = 0; i < PULSE_LIMIT; i++) begin
            if (uncorrectable !== 1'b1) begin
                break;
            end
            width++;
            @(negedge clk);
        end
        if (uncorrectable === 1'b1) begin
            report_error("uncorrectable stayed high past the wait limit");
        end
    endtask

    task automatic test_reset_values();
        check_value("read1_data", read1_data, 32'd0);
        check_value("read2_data", read2_data, 32'd0);
        check_value("read1_status", 32'(read1_status), 32'(VOTE_CLEAN));
        check_value("read2_status", 32'(read2_status), 32'(VOTE_CLEAN));
        check_count();
        check_value("uncorrectable", 32'(uncorrectable), 32'd0);
    endtask

    task automatic test_clean_reads();
        logic [DATA_WIDTH-1:0] data;
        for (int a = 0; a < DEPTH; a++) begin
            data = $random(seed);
            store_word(a, data);
        end
        // Different addresses on the two ports
        for (int a = 0; a < DEPTH; a++) begin
            run_cycle(rd_at(a), rd_at((a + 17) % DEPTH), '0);
            check_port(1, a, VOTE_CLEAN);
            check_port(2, (a + 17) % DEPTH, VOTE_CLEAN);
        end
        // Same address on both ports
        for (int a = 0; a < DEPTH; a += 8) begin
            run_cycle(rd_at(a), rd_at(a), '0);
            check_port(1, a, VOTE_CLEAN);
            check_port(2, a, VOTE_CLEAN);
        end
        // Idle ports hold the result of the last shared-address read
        run_cycle('0, '0, '0);
        check_port(1, DEPTH - 8, VOTE_CLEAN);
        check_port(2, DEPTH - 8, VOTE_CLEAN);
        check_count();
        check_value("uncorrectable", 32'(uncorrectable), 32'd0);
    endtask

    task automatic test_single_correction();
        int addr;
        int port;
        // One faulty copy per pass, alternating the read port
        for (int b = 0; b < NUM_BANKS; b++) begin
            addr = 5 + 4 * b;
            port = (b % 2) + 1;
            inject_fault(bank_id_e'(b), addr, 32'h1 << b);
            read_one(port, addr);
            exp_scrub++;
            check_port(port, addr, VOTE_CORRECTED);
            check_count();
            check_value("uncorrectable", 32'(uncorrectable), 32'd0);
            // The scrub repaired the copy at the same edge
            read_one(port, addr);
            check_port(port, addr, VOTE_CLEAN);
            check_count();
        end
    endtask

    task automatic test_port_priority();
        inject_fault(BANK_2, 20, 32'hffff_ffff);
        inject_fault(BANK_0, 40, 32'h8000_0000);
        run_cycle(rd_at(20), rd_at(40), '0);
        // Only port 1's fix is written
        exp_scrub++;
        check_port(1, 20, VOTE_CORRECTED);
        check_port(2, 40, VOTE_CORRECTED);
        check_count();
        read_one(1, 20);
        check_port(1, 20, VOTE_CLEAN);
        check_count();
        // Port 2's word was left faulty
        read_one(2, 40);
        exp_scrub++;
        check_port(2, 40, VOTE_CORRECTED);
        check_count();
        read_one(2, 40);
        check_port(2, 40, VOTE_CLEAN);
        check_count();
    endtask

    task automatic test_store_bypass();
        logic [DATA_WIDTH-1:0] data;
        data = $random(seed);
        run_cycle(rd_at(30), rd_at(30), wr_at(30, data));
        check_value("read1_data", read1_data, data);
        check_port(1, 30, VOTE_CLEAN);
        check_port(2, 30, VOTE_CLEAN);
        check_count();
        // Faulted word, the store rewrites every copy and no scrub happens
        inject_fault(BANK_1, 31, 32'h0f0f_0f0f);
        data = $random(seed);
        run_cycle(rd_at(31), '0, wr_at(31, data));
        check_value("read1_data", read1_data, data);
        check_port(1, 31, VOTE_CLEAN);
        check_count();
        read_one(2, 31);
        check_port(2, 31, VOTE_CLEAN);
        check_count();
    endtask

    task automatic test_uncorrectable();
        int width;
        inject_fault(BANK_1, 50, 32'h0000_00ff);
        inject_fault(BANK_2, 50, 32'h0000_ff00);
        read_one(1, 50);
        // Bank 0 still holds the true word
        check_port(1, 50, VOTE_FAILED);
        check_value("uncorrectable", 32'(uncorrectable), 32'd1);
        check_count();
        wait_pulse_end(width);
        check_value("uncorrectable pulse width", 32'(width), 32'd1);
        store_word(50, shadow_at(50));
        read_one(2, 50);
        check_port(2, 50, VOTE_CLEAN);
        check_count();
    endtask

    // Ends the run if the tests stop making progress
    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clk);
        end
        $display("ERROR: simulation did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        seed      = 60;
        exp_scrub = 0;
        n_checks  = 0;
        n_errors  = 0;
        arst_n    = 1'b0;
        rd1       = '0;
        rd2       = '0;
        wr        = '0;
        inject    = '0;
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
        end
        arst_n <= 1'b1;
        @(negedge clk);

        test_reset_values();
        test_clean_reads();
        test_single_correction();
        test_port_priority();
        test_store_bypass();
        test_uncorrectable();

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- tmr_bank.sv
/*
 * One copy of the register file
 * Two combinational read ports and a single clocked write port that
 * takes the store, the fault injection or the scrub fix, in that order
 */
module tmr_bank #(
    parameter tmr_pkg::bank_id_e bank_idx = tmr_pkg::BANK_0
) (
    input  logic                             clk,
    input  logic [tmr_pkg::ADDR_WIDTH-1:0]   rd1_addr,
    input  logic [tmr_pkg::ADDR_WIDTH-1:0]   rd2_addr,
    input  tmr_pkg::wr_req_t                 wr,
    input  tmr_pkg::inject_t                 inject,
    input  tmr_pkg::fix_req_t                fix,
    output logic [tmr_pkg::DATA_WIDTH-1:0]   rd1_word,
    output logic [tmr_pkg::DATA_WIDTH-1:0]   rd2_word
);

    import tmr_pkg::*;

    // Storage array, contents are not cleared by reset
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // Injection and fix only take effect when they name this copy
    logic inject_hit;
    logic fix_hit;

    // The fix is applied only when nothing with higher priority uses the port
    logic fix_apply;

    assign inject_hit = inject.en && (inject.bank == bank_idx);
    assign fix_hit    = fix.en && (fix.bank == bank_idx);
    assign fix_apply  = fix_hit && !wr.en && !inject_hit;

    // Both read ports are asynchronous, the voters register the result
    assign rd1_word = mem[rd1_addr];
    assign rd2_word = mem[rd2_addr];

    // Single write port per copy
    // A store always wins since it refreshes all three copies at once
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end else if (inject_hit) begin
            mem[inject.addr] <= inject.data;
        end else if (fix_apply) begin
            mem[fix.addr] <= fix.data;
        end
    end

    // The voter picked this copy as the odd one out, so the word about to
    // be overwritten must really differ from the majority word
    a_fix_targets_bad_word: assert property (
        @(posedge clk) fix_apply |-> (mem[fix.addr] != fix.data)
    ) else $error("bank %0d: fix applied to a word that already matches", bank_idx);

endmodule

//--- tmr_pkg.sv
/*
 * Shared definitions for the triple-redundant 2R1W register file:
 * sizes, bank and vote status enums, and the request, vote and
 * fix structs passed between banks, voters and the scrubber
 */
package tmr_pkg;

    // Word width of every bank
    localparam int DATA_WIDTH = 32;

    // Words held by each bank
    localparam int DEPTH = 64;

    // Address bits needed to cover DEPTH
    localparam int ADDR_WIDTH = 6;

    // Number of redundant copies
    localparam int NUM_BANKS = 3;

    // Width of the saturating scrub counter
    localparam int COUNT_WIDTH = 16;

    // Names one of the three copies
    typedef enum logic [1:0] {
        BANK_0 = 2'd0,
        BANK_1 = 2'd1,
        BANK_2 = 2'd2
    } bank_id_e;

    // Outcome of a word-level majority vote
    typedef enum logic [1:0] {
        VOTE_CLEAN     = 2'd0,
        VOTE_CORRECTED = 2'd1,
        VOTE_FAILED    = 2'd2
    } vote_status_e;

    // Read request for one port
    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
    } rd_req_t;

    // Store request, written to all three banks
    typedef struct packed {
        logic                  en;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } wr_req_t;

    // Deterministic fault injection, overwrites a single bank
    typedef struct packed {
        logic                  en;
        bank_id_e              bank;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } inject_t;

    // Combinational result of one voter
    // When all banks differ the data field carries bank 0's word
    typedef struct packed {
        vote_status_e          status;
        bank_id_e              bad_bank;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } vote_t;

    // Scrub write-back into the bank that lost the vote
    typedef struct packed {
        logic                  en;
        bank_id_e              bank;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } fix_req_t;

endpackage

//--- tmr_scrubber.sv
/*
 * Scrub controller shared by both read ports
 * Picks at most one write-back per cycle with port 1 first, drops fixes
 * that collide with a store, counts written fixes and flags failed votes
 */
module tmr_scrubber (
    input  logic                              clk,
    input  logic                              arst_n,
    input  tmr_pkg::vote_t                    vote1,
    input  tmr_pkg::vote_t                    vote2,
    input  logic                              rd1_en,
    input  logic                              rd2_en,
    input  tmr_pkg::wr_req_t                  wr,
    output tmr_pkg::fix_req_t                 fix,
    output logic [tmr_pkg::COUNT_WIDTH-1:0]   scrub_count,
    output logic                              uncorrectable
);

    import tmr_pkg::*;

    // A store to the voted address makes the vote stale
    logic wr_hit1;
    logic wr_hit2;

    // Ports asking for a write-back this cycle
    logic cand1;
    logic cand2;

    // Ports that will return VOTE_FAILED on the next cycle
    logic fail1;
    logic fail2;

    assign wr_hit1 = wr.en && (wr.addr == vote1.addr);
    assign wr_hit2 = wr.en && (wr.addr == vote2.addr);

    assign cand1 = rd1_en && (vote1.status == VOTE_CORRECTED) && !wr_hit1;
    assign cand2 = rd2_en && (vote2.status == VOTE_CORRECTED) && !wr_hit2;

    // A bypassed read returns clean data, so it never reports a failure
    assign fail1 = rd1_en && (vote1.status == VOTE_FAILED) && !wr_hit1;
    assign fail2 = rd2_en && (vote2.status == VOTE_FAILED) && !wr_hit2;

    // Fix selection, port 1 wins and port 2's request is dropped
    // Identical requests from both ports collapse into the one fix
    always_comb begin
        if (cand1) begin
            fix.en   = 1'b1;
            fix.bank = vote1.bad_bank;
            fix.addr = vote1.addr;
            fix.data = vote1.data;
        end else if (cand2) begin
            fix.en   = 1'b1;
            fix.bank = vote2.bad_bank;
            fix.addr = vote2.addr;
            fix.data = vote2.data;
        end else begin
            fix.en   = 1'b0;
            fix.bank = BANK_0;
            fix.addr = '0;
            fix.data = '0;
        end
    end

    // Saturating count of written fixes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scrub_count <= '0;
        end else if (fix.en && !(&scrub_count)) begin
            scrub_count <= scrub_count + 1'b1;
        end
    end

    // One-cycle pulse lined up with the registered read data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            uncorrectable <= 1'b0;
        end else begin
            uncorrectable <= fail1 || fail2;
        end
    end

    // A fix never races a store to the same word
    a_fix_store_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n)
        fix.en |-> (!wr.en || (wr.addr != fix.addr))
    ) else $error("scrubber: fix collided with a store");

endmodule

//--- tmr_voter.sv
/*
 * Word-level majority voter for one read port
 * Finds the odd copy out, forms the vote result for the scrubber and
 * registers read data and status with a new-data store bypass
 */
module tmr_voter (
    input  logic                             clk,
    input  logic                             arst_n,
    input  tmr_pkg::rd_req_t                 rd,
    input  tmr_pkg::wr_req_t                 wr,
    input  logic [tmr_pkg::DATA_WIDTH-1:0]   word0,
    input  logic [tmr_pkg::DATA_WIDTH-1:0]   word1,
    input  logic [tmr_pkg::DATA_WIDTH-1:0]   word2,
    output tmr_pkg::vote_t                   vote,
    output logic [tmr_pkg::DATA_WIDTH-1:0]   read_data,
    output tmr_pkg::vote_status_e            read_status
);

    import tmr_pkg::*;

    // Pairwise equality of the three copies
    logic eq01;
    logic eq02;
    logic eq12;

    // Store to the address being read in this same cycle
    logic wr_hit;

    assign eq01   = (word0 == word1);
    assign eq02   = (word0 == word2);
    assign eq12   = (word1 == word2);
    assign wr_hit = wr.en && (wr.addr == rd.addr);

    // Vote over whole words
    // Bank 0 is the default suspect whenever words 0 and 1 and words 0
    // and 2 both disagree
    always_comb begin
        vote.addr = rd.addr;
        if (eq01 && eq02) begin
            vote.status   = VOTE_CLEAN;
            vote.bad_bank = BANK_0;
            vote.data     = word0;
        end else if (eq01) begin
            vote.status   = VOTE_CORRECTED;
            vote.bad_bank = BANK_2;
            vote.data     = word0;
        end else if (eq02) begin
            vote.status   = VOTE_CORRECTED;
            vote.bad_bank = BANK_1;
            vote.data     = word0;
        end else if (eq12) begin
            // Banks 1 and 2 outvote bank 0
            vote.status   = VOTE_CORRECTED;
            vote.bad_bank = BANK_0;
            vote.data     = word1;
        end else begin
            // No majority, hand back bank 0's word as is
            vote.status   = VOTE_FAILED;
            vote.bad_bank = BANK_0;
            vote.data     = word0;
        end
    end

    // Output register, one cycle read latency
    // Data and status hold while the port is idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            read_data   <= '0;
            read_status <= VOTE_CLEAN;
        end else if (rd.en) begin
            if (wr_hit) begin
                // New data behaviour, the store rewrites all copies anyway
                read_data   <= wr.data;
                read_status <= VOTE_CLEAN;
            end else begin
                read_data   <= vote.data;
                read_status <= vote.status;
            end
        end
    end

    // A corrected status always comes from exactly one matching pair of words
    a_corrected_has_pair: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rd.en && !wr_hit && (vote.status == VOTE_CORRECTED))
        |-> ($countones({eq01, eq02, eq12}) == 1)
    ) else $error("voter: corrected vote without exactly two equal words");

endmodule

//--- voting_sram_2r1w.sv
/*
 * Top level of the triple-redundant 2R1W register file
 * Three banks, one voter per read port and the shared scrubber
 */
module voting_sram_2r1w (
    input  logic                              clk,
    input  logic                              arst_n,
    input  tmr_pkg::rd_req_t                  rd1,
    input  tmr_pkg::rd_req_t                  rd2,
    input  tmr_pkg::wr_req_t                  wr,
    input  tmr_pkg::inject_t                  inject,
    output logic [tmr_pkg::DATA_WIDTH-1:0]    read1_data,
    output logic [tmr_pkg::DATA_WIDTH-1:0]    read2_data,
    output tmr_pkg::vote_status_e             read1_status,
    output tmr_pkg::vote_status_e             read2_status,
    output logic [tmr_pkg::COUNT_WIDTH-1:0]   scrub_count,
    output logic                              uncorrectable
);

    import tmr_pkg::*;

    // Per-bank words seen by read port 1 and read port 2
    logic [DATA_WIDTH-1:0] bank_rd1_word [NUM_BANKS];
    logic [DATA_WIDTH-1:0] bank_rd2_word [NUM_BANKS];

    // Combinational votes from the two ports
    vote_t vote1;
    vote_t vote2;

    // Selected write-back, shared by all banks
    fix_req_t fix;

    // Identical copies, each told which bank it is
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        tmr_bank #(
            .bank_idx (bank_id_e'(g))
        ) i_tmr_bank (
            .clk      (clk),
            .rd1_addr (rd1.addr),
            .rd2_addr (rd2.addr),
            .wr       (wr),
            .inject   (inject),
            .fix      (fix),
            .rd1_word (bank_rd1_word[g]),
            .rd2_word (bank_rd2_word[g])
        );
    end

    // Read port 1
    tmr_voter i_tmr_voter_1 (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd          (rd1),
        .wr          (wr),
        .word0       (bank_rd1_word[0]),
        .word1       (bank_rd1_word[1]),
        .word2       (bank_rd1_word[2]),
        .vote        (vote1),
        .read_data   (read1_data),
        .read_status (read1_status)
    );

    // Read port 2
    tmr_voter i_tmr_voter_2 (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd          (rd2),
        .wr          (wr),
        .word0       (bank_rd2_word[0]),
        .word1       (bank_rd2_word[1]),
        .word2       (bank_rd2_word[2]),
        .vote        (vote2),
        .read_data   (read2_data),
        .read_status (read2_status)
    );

    // Write-back arbitration and statistics
    tmr_scrubber i_tmr_scrubber (
        .clk           (clk),
        .arst_n        (arst_n),
        .vote1         (vote1),
        .vote2         (vote2),
        .rd1_en        (rd1.en),
        .rd2_en        (rd2.en),
        .wr            (wr),
        .fix           (fix),
        .scrub_count   (scrub_count),
        .uncorrectable (uncorrectable)
    );

endmodule
